// File: Bender.yml
package:
  name: cache_miss_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/cache_miss_pkg.sv
      - hw/miss_alloc.sv
      - hw/miss_handler.sv
      - hw/dma_arbiter.sv
      - hw/cache_miss_unit.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_cache_miss_unit.sv

// File: compile.f
+incdir+hw
hw/cache_miss_pkg.sv
hw/miss_alloc.sv
hw/miss_handler.sv
hw/dma_arbiter.sv
hw/cache_miss_unit.sv
verification/tb_cache_miss_unit.sv

// File: hw/cache_miss_consts.svh
`ifndef CACHE_MISS_CONSTS_SVH
`define CACHE_MISS_CONSTS_SVH

// byte address width
`define CM_ADDR_W 32
// bytes per data word
`define CM_WORD_BYTES 4
// words per cache block
`define CM_BLOCK_WORDS 8
// cache geometry
`define CM_SETS 64
`define CM_WAYS 4
// number of miss handlers in the bank
`define CM_HANDLERS 4

// derived field widths
// offset covers CM_BLOCK_WORDS * CM_WORD_BYTES bytes
`define CM_OFFSET_W 5
// log2 of CM_SETS
`define CM_INDEX_W 6
// whatever is left above index and offset
`define CM_TAG_W 21
// log2 of CM_WAYS
`define CM_WAY_W 2
// log2 of CM_HANDLERS
`define CM_ID_W 2

`endif

// File: hw/cache_miss_pkg.sv
`default_nettype none

`include "cache_miss_consts.svh"

package cache_miss_pkg;

  // one miss as seen by the tag stage
  // victim fields describe the way chosen for replacement
  typedef struct packed {
    logic [`CM_ADDR_W-1:0] addr;
    logic [`CM_WAY_W-1:0]  victim_way;
    logic [`CM_TAG_W-1:0]  victim_tag;
    logic                  victim_valid;
    logic                  victim_dirty;
  } miss_req_t;

  // dma command kinds
  typedef enum logic [0:0] {
    dma_refill_addr = 1'b0,
    dma_evict_addr  = 1'b1
  } dma_cmd_e;

  // command toward the dma engine
  // id is the issuing handler, echoed back with done
  typedef struct packed {
    dma_cmd_e              cmd;
    logic [`CM_ADDR_W-1:0] addr;
    logic [`CM_ID_W-1:0]   id;
  } dma_req_t;

  // query into store buffer and tag buffer before eviction
  typedef struct packed {
    logic                   valid;
    logic [`CM_INDEX_W-1:0] index;
    logic [`CM_WAY_W-1:0]   way;
  } snoop_query_t;

  // per handler miss FSM
  typedef enum logic [2:0] {
    st_idle,
    st_refill_addr,
    st_snoop_wait,
    st_evict_addr,
    st_evict_data,
    st_fill_wait
  } handler_state_e;

endpackage

`default_nettype wire

// File: hw/cache_miss_unit.sv
`default_nettype none

`include "cache_miss_consts.svh"

module cache_miss_unit (
  input  wire logic                                        clk_i,
  input  wire logic                                        reset_i,
  input  wire logic                                        miss_valid_i,
  input  cache_miss_pkg::miss_req_t                        miss_req_i,
  output logic                                             miss_ready_o,
  output logic [`CM_ID_W-1:0]                              miss_id_o,
  output logic                                             dma_valid_o,
  output cache_miss_pkg::dma_req_t                         dma_req_o,
  input  wire logic                                        dma_ready_i,
  input  wire logic                                        dma_done_i,
  input  wire logic [`CM_ID_W-1:0]                         dma_done_id_i,
  output logic [`CM_HANDLERS-1:0]                          evict_pending_o,
  output cache_miss_pkg::snoop_query_t [`CM_HANDLERS-1:0]  snoop_o,
  input  wire logic [`CM_HANDLERS-1:0]                     snoop_hit_i,
  output logic [`CM_HANDLERS-1:0]                          miss_busy_o
);

  logic [`CM_HANDLERS-1:0]                     load;
  cache_miss_pkg::miss_req_t                   load_req;
  logic [`CM_HANDLERS-1:0]                     hreq_v;
  cache_miss_pkg::dma_req_t [`CM_HANDLERS-1:0] hreq;
  logic [`CM_HANDLERS-1:0]                     accept;
  logic [`CM_HANDLERS-1:0]                     done;

  // intake into a free handler
  miss_alloc u_alloc (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .miss_valid_i (miss_valid_i),
    .miss_req_i   (miss_req_i),
    .miss_ready_o (miss_ready_o),
    .miss_id_o    (miss_id_o),
    .busy_i       (miss_busy_o),
    .load_o       (load),
    .req_o        (load_req)
  );

  // handler bank, id equals position
  for (genvar g = 0; g < `CM_HANDLERS; g++) begin : g_handler
    miss_handler #(
      .ID (g)
    ) u_handler (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .load_i          (load[g]),
      .req_i           (load_req),
      .busy_o          (miss_busy_o[g]),
      .dma_req_v_o     (hreq_v[g]),
      .dma_req_o       (hreq[g]),
      .dma_accept_i    (accept[g]),
      .dma_done_i      (done[g]),
      .evict_pending_o (evict_pending_o[g]),
      .snoop_o         (snoop_o[g]),
      .snoop_hit_i     (snoop_hit_i[g])
    );
  end

  // one shared dma command port
  dma_arbiter u_arb (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_v_i       (hreq_v),
    .req_i         (hreq),
    .accept_o      (accept),
    .dma_valid_o   (dma_valid_o),
    .dma_req_o     (dma_req_o),
    .dma_ready_i   (dma_ready_i),
    .dma_done_i    (dma_done_i),
    .dma_done_id_i (dma_done_id_i),
    .done_o        (done)
  );

endmodule

`default_nettype wire

// File: hw/dma_arbiter.sv
`default_nettype none

`include "cache_miss_consts.svh"

module dma_arbiter (
  input  wire logic                                    clk_i,
  input  wire logic                                    reset_i,
  input  wire logic [`CM_HANDLERS-1:0]                 req_v_i,
  input  cache_miss_pkg::dma_req_t [`CM_HANDLERS-1:0]  req_i,
  output logic [`CM_HANDLERS-1:0]                      accept_o,
  output logic                                         dma_valid_o,
  output cache_miss_pkg::dma_req_t                     dma_req_o,
  input  wire logic                                    dma_ready_i,
  input  wire logic                                    dma_done_i,
  input  wire logic [`CM_ID_W-1:0]                     dma_done_id_i,
  output logic [`CM_HANDLERS-1:0]                      done_o
);

  // next handler to look at first
  logic [`CM_ID_W-1:0] ptr_r;
  // grant kept across a stalled transfer
  logic [`CM_ID_W-1:0] grant_r;
  logic                hold_r;

  logic [`CM_ID_W-1:0] grant;
  logic                xfer;

  // search from ptr_r, wrapping around the handler bank
  always_comb begin
    int  cand;
    logic found;
    cand  = 0;
    found = 1'b0;
    grant = ptr_r;
    if (hold_r) begin
      grant = grant_r;
    end else begin
      for (int k = 0; k < `CM_HANDLERS; k++) begin
        cand = (int'(ptr_r) + k) % `CM_HANDLERS;
        if (!found && req_v_i[cand]) begin
          found = 1'b1;
          grant = `CM_ID_W'(cand);
        end
      end
    end
  end

  assign dma_valid_o = req_v_i[grant];
  assign dma_req_o   = req_i[grant];
  assign xfer        = dma_valid_o && dma_ready_i;

  always_comb begin
    accept_o = '0;
    accept_o[grant] = xfer;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_r   <= '0;
      grant_r <= '0;
      hold_r  <= 1'b0;
    end else begin
      // lock the grant while the dma port back-pressures
      hold_r  <= dma_valid_o && !dma_ready_i;
      grant_r <= grant;
      if (xfer) begin
        ptr_r <= `CM_ID_W'((int'(grant) + 1) % `CM_HANDLERS);
      end
    end
  end

  // done pulse decoded back to its handler
  always_comb begin
    for (int i = 0; i < `CM_HANDLERS; i++) begin
      done_o[i] = dma_done_i && (dma_done_id_i == `CM_ID_W'(i));
    end
  end

  // stalled command must not change under the dma engine
  a_stable_on_stall: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (dma_valid_o && !dma_ready_i) |=> (dma_valid_o && $stable(dma_req_o))
  );

endmodule

`default_nettype wire

// File: hw/miss_alloc.sv
`default_nettype none

`include "cache_miss_consts.svh"

module miss_alloc (
  input  wire logic                     clk_i,
  input  wire logic                     reset_i,
  input  wire logic                     miss_valid_i,
  input  cache_miss_pkg::miss_req_t     miss_req_i,
  output logic                          miss_ready_o,
  output logic [`CM_ID_W-1:0]           miss_id_o,
  input  wire logic [`CM_HANDLERS-1:0]  busy_i,
  output logic [`CM_HANDLERS-1:0]       load_o,
  output cache_miss_pkg::miss_req_t     req_o
);

  logic [`CM_HANDLERS-1:0] free_oh;
  logic [`CM_ID_W-1:0]     free_id;
  logic                    any_free;

  // lowest numbered idle handler wins
  always_comb begin
    free_oh  = '0;
    free_id  = '0;
    any_free = 1'b0;
    for (int i = 0; i < `CM_HANDLERS; i++) begin
      if (!busy_i[i] && !any_free) begin
        any_free   = 1'b1;
        free_id    = `CM_ID_W'(i);
        free_oh[i] = 1'b1;
      end
    end
  end

  // ready only depends on busy, never on valid
  assign miss_ready_o = any_free;
  assign miss_id_o    = free_id;

  // load strobe on the transfer cycle only
  assign load_o = (miss_valid_i && any_free) ? free_oh : '0;

  // every handler samples the same request, load picks the one
  assign req_o = miss_req_i;

  // a loaded handler must really take the miss and report busy next cycle
  a_load_onehot_free: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (load_o != '0) |=> ((busy_i & $past(load_o)) == $past(load_o))
  );

endmodule

`default_nettype wire

// File: hw/miss_handler.sv
`default_nettype none

`include "cache_miss_consts.svh"

module miss_handler #(
  parameter int unsigned ID = 0
) (
  input  wire logic                      clk_i,
  input  wire logic                      reset_i,
  input  wire logic                      load_i,
  input  cache_miss_pkg::miss_req_t      req_i,
  output logic                           busy_o,
  output logic                           dma_req_v_o,
  output cache_miss_pkg::dma_req_t       dma_req_o,
  input  wire logic                      dma_accept_i,
  input  wire logic                      dma_done_i,
  output logic                           evict_pending_o,
  output cache_miss_pkg::snoop_query_t   snoop_o,
  input  wire logic                      snoop_hit_i
);

  cache_miss_pkg::handler_state_e state_r;
  cache_miss_pkg::handler_state_e state_n;

  // captured miss, payload only
  cache_miss_pkg::miss_req_t req_r;

  logic [`CM_TAG_W-1:0]   miss_tag;
  logic [`CM_INDEX_W-1:0] miss_index;
  logic                   need_evict;

  // request is latched on the accepting edge
  always_ff @(posedge clk_i) begin
    if (load_i && (state_r == cache_miss_pkg::st_idle)) begin
      req_r <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= cache_miss_pkg::st_idle;
    end else begin
      state_r <= state_n;
    end
  end

  // split the miss address into its fields
  assign miss_tag   = req_r.addr[`CM_ADDR_W-1 -: `CM_TAG_W];
  assign miss_index = req_r.addr[`CM_OFFSET_W +: `CM_INDEX_W];

  // only a valid dirty victim has to be written back
  assign need_evict = req_r.victim_valid && req_r.victim_dirty;

  always_comb begin
    state_n = state_r;
    case (state_r)
      cache_miss_pkg::st_idle: begin
        if (load_i) begin
          state_n = cache_miss_pkg::st_refill_addr;
        end
      end
      cache_miss_pkg::st_refill_addr: begin
        // skip the snoop wait when no buffered store targets the victim
        if (dma_accept_i) begin
          if (!need_evict) begin
            state_n = cache_miss_pkg::st_fill_wait;
          end else if (snoop_hit_i) begin
            state_n = cache_miss_pkg::st_snoop_wait;
          end else begin
            state_n = cache_miss_pkg::st_evict_addr;
          end
        end
      end
      cache_miss_pkg::st_snoop_wait: begin
        // hold off until sbuf and tbuf drain the victim set and way
        if (!snoop_hit_i) begin
          state_n = cache_miss_pkg::st_evict_addr;
        end
      end
      cache_miss_pkg::st_evict_addr: begin
        if (dma_accept_i) begin
          state_n = cache_miss_pkg::st_evict_data;
        end
      end
      cache_miss_pkg::st_evict_data: begin
        // first done belongs to the eviction
        if (dma_done_i) begin
          state_n = cache_miss_pkg::st_fill_wait;
        end
      end
      cache_miss_pkg::st_fill_wait: begin
        if (dma_done_i) begin
          state_n = cache_miss_pkg::st_idle;
        end
      end
      default: begin
        state_n = cache_miss_pkg::st_idle;
      end
    endcase
  end

  assign busy_o = (state_r != cache_miss_pkg::st_idle);

  // command request in both address states
  assign dma_req_v_o = (state_r == cache_miss_pkg::st_refill_addr) ||
                       (state_r == cache_miss_pkg::st_evict_addr);

  always_comb begin
    dma_req_o.id = `CM_ID_W'(ID);
    if (state_r == cache_miss_pkg::st_evict_addr) begin
      dma_req_o.cmd  = cache_miss_pkg::dma_evict_addr;
      dma_req_o.addr = {req_r.victim_tag, miss_index, {`CM_OFFSET_W{1'b0}}};
    end else begin
      dma_req_o.cmd  = cache_miss_pkg::dma_refill_addr;
      dma_req_o.addr = {miss_tag, miss_index, {`CM_OFFSET_W{1'b0}}};
    end
  end

  // dma must not complete the refill before the writeback
  assign evict_pending_o = (state_r == cache_miss_pkg::st_evict_data);

  // set and way of the victim, qualified only while waiting
  assign snoop_o.valid = (state_r == cache_miss_pkg::st_snoop_wait);
  assign snoop_o.index = miss_index;
  assign snoop_o.way   = req_r.victim_way;

  // done routed by id must only reach a handler with a miss in flight
  a_no_done_idle: assert property (
    @(posedge clk_i) disable iff (reset_i)
    dma_done_i |-> (state_r != cache_miss_pkg::st_idle)
  );

  // arbiter only accepts what this handler is requesting
  a_accept_needs_req: assert property (
    @(posedge clk_i) disable iff (reset_i)
    dma_accept_i |-> dma_req_v_o
  );

endmodule

`default_nettype wire

// File: verification/tb_cache_miss_unit.sv
`default_nettype none

`include "cache_miss_consts.svh"

module tb_cache_miss_unit;

  localparam int TIMEOUT = 200;

  logic                                            clk_i;
  logic                                            reset_i;
  logic                                            miss_valid_i;
  cache_miss_pkg::miss_req_t                       miss_req_i;
  logic                                            miss_ready_o;
  logic [`CM_ID_W-1:0]                             miss_id_o;
  logic                                            dma_valid_o;
  cache_miss_pkg::dma_req_t                        dma_req_o;
  logic                                            dma_ready_i;
  logic                                            dma_done_i;
  logic [`CM_ID_W-1:0]                             dma_done_id_i;
  logic [`CM_HANDLERS-1:0]                         evict_pending_o;
  cache_miss_pkg::snoop_query_t [`CM_HANDLERS-1:0] snoop_o;
  logic [`CM_HANDLERS-1:0]                         snoop_hit_i;
  logic [`CM_HANDLERS-1:0]                         miss_busy_o;

  // xorshift state
  logic [31:0] rng_state = 32'h3c45;

  cache_miss_unit UUT (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .miss_valid_i    (miss_valid_i),
    .miss_req_i      (miss_req_i),
    .miss_ready_o    (miss_ready_o),
    .miss_id_o       (miss_id_o),
    .dma_valid_o     (dma_valid_o),
    .dma_req_o       (dma_req_o),
    .dma_ready_i     (dma_ready_i),
    .dma_done_i      (dma_done_i),
    .dma_done_id_i   (dma_done_id_i),
    .evict_pending_o (evict_pending_o),
    .snoop_o         (snoop_o),
    .snoop_hit_i     (snoop_hit_i),
    .miss_busy_o     (miss_busy_o)
  );

  always #2 clk_i = ~clk_i;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // random address, way and tag, victim bits given
  function automatic cache_miss_pkg::miss_req_t make_req(input logic valid, input logic dirty);
    cache_miss_pkg::miss_req_t r;
    logic [31:0] w;
    r.addr = next_rand();
    w = next_rand();
    r.victim_way = w[`CM_WAY_W-1:0];
    w = next_rand();
    r.victim_tag = w[`CM_TAG_W-1:0];
    r.victim_valid = valid;
    r.victim_dirty = dirty;
    return r;
  endfunction

  // block aligned address, refill from miss tag or eviction from victim tag
  function automatic cache_miss_pkg::dma_req_t expect_cmd(input cache_miss_pkg::miss_req_t req,
                                                          input logic evict,
                                                          input logic [`CM_ID_W-1:0] id);
    cache_miss_pkg::dma_req_t c;
    c.id = id;
    if (evict) begin
      c.cmd  = cache_miss_pkg::dma_evict_addr;
      c.addr = {req.victim_tag, req.addr[`CM_OFFSET_W +: `CM_INDEX_W], {`CM_OFFSET_W{1'b0}}};
    end else begin
      c.cmd  = cache_miss_pkg::dma_refill_addr;
      c.addr = {req.addr[`CM_ADDR_W-1:`CM_OFFSET_W], {`CM_OFFSET_W{1'b0}}};
    end
    return c;
  endfunction

  // hold valid until the allocator is ready, return the id it names
  task automatic send_miss(input cache_miss_pkg::miss_req_t req, output logic [`CM_ID_W-1:0] id);
    int n;
    n = 0;
    @(posedge clk_i);
    #1;
    miss_valid_i = 1'b1;
    miss_req_i   = req;
    @(negedge clk_i);
    while (!miss_ready_o) begin
      n++;
      if (n > TIMEOUT) report_failure("timeout: miss request was never accepted");
      @(negedge clk_i);
    end
    id = miss_id_o;
    @(posedge clk_i);
    #1;
    miss_valid_i = 1'b0;
  endtask

  // dma responder, command side with optional stall cycles
  task automatic take_cmd(input int stall, output cache_miss_pkg::dma_req_t cmd);
    int n;
    int s;
    n = 0;
    @(negedge clk_i);
    while (!dma_valid_o) begin
      n++;
      if (n > TIMEOUT) report_failure("timeout: no DMA command appeared");
      @(negedge clk_i);
    end
    cmd = dma_req_o;
    // command must not move while ready is low
    for (s = 0; s < stall; s++) begin
      @(negedge clk_i);
      check("dma_valid_o", dma_valid_o, 1'b1);
      check("dma_req_o", dma_req_o, cmd);
    end
    @(posedge clk_i);
    #1;
    dma_ready_i = 1'b1;
    @(negedge clk_i);
    check("dma_req_o", dma_req_o, cmd);
    @(posedge clk_i);
    #1;
    dma_ready_i = 1'b0;
  endtask

  // one cycle done pulse tagged with the handler id
  task automatic send_done(input logic [`CM_ID_W-1:0] id);
    @(posedge clk_i);
    #1;
    dma_done_i    = 1'b1;
    dma_done_id_i = id;
    @(posedge clk_i);
    #1;
    dma_done_i    = 1'b0;
  endtask

  task automatic wait_idle(input logic [`CM_ID_W-1:0] id);
    int n;
    n = 0;
    @(negedge clk_i);
    while (miss_busy_o[id]) begin
      n++;
      if (n > TIMEOUT) report_failure($sformatf("timeout: handler %0d never went idle", id));
      @(negedge clk_i);
    end
  endtask

  task automatic expect_no_cmd(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check("dma_valid_o", dma_valid_o, 1'b0);
    end
  endtask

  task automatic test_reset();
    @(negedge clk_i);
    check("miss_ready_o", miss_ready_o, 1'b1);
    check("dma_valid_o", dma_valid_o, 1'b0);
    check("miss_busy_o", miss_busy_o, '0);
    check("evict_pending_o", evict_pending_o, '0);
    for (int i = 0; i < `CM_HANDLERS; i++) begin
      check($sformatf("snoop_o[%0d].valid", i), snoop_o[i].valid, 1'b0);
    end
  endtask

  // victim either clean or invalid, refill only
  task automatic test_clean(input logic valid, input logic dirty);
    cache_miss_pkg::miss_req_t req;
    cache_miss_pkg::dma_req_t  cmd;
    logic [`CM_ID_W-1:0]       id;
    req = make_req(valid, dirty);
    send_miss(req, id);
    take_cmd(1, cmd);
    check("dma_req_o", cmd, expect_cmd(req, 1'b0, id));
    expect_no_cmd(4);
    check("miss_busy_o[id]", miss_busy_o[id], 1'b1);
    send_done(id);
    wait_idle(id);
  endtask

  task automatic test_dirty();
    cache_miss_pkg::miss_req_t req;
    cache_miss_pkg::dma_req_t  cmd;
    logic [`CM_ID_W-1:0]       id;
    req = make_req(1'b1, 1'b1);
    send_miss(req, id);
    take_cmd(0, cmd);
    check("dma_req_o", cmd, expect_cmd(req, 1'b0, id));
    take_cmd(2, cmd);
    check("dma_req_o", cmd, expect_cmd(req, 1'b1, id));
    @(negedge clk_i);
    check("evict_pending_o[id]", evict_pending_o[id], 1'b1);
    // first done closes the writeback
    send_done(id);
    @(negedge clk_i);
    check("evict_pending_o[id]", evict_pending_o[id], 1'b0);
    check("miss_busy_o[id]", miss_busy_o[id], 1'b1);
    send_done(id);
    wait_idle(id);
  endtask

  task automatic test_snoop();
    cache_miss_pkg::miss_req_t req;
    cache_miss_pkg::dma_req_t  cmd;
    logic [`CM_ID_W-1:0]       id;
    req = make_req(1'b1, 1'b1);
    @(posedge clk_i);
    #1;
    snoop_hit_i = '1;
    send_miss(req, id);
    take_cmd(0, cmd);
    check("dma_req_o", cmd, expect_cmd(req, 1'b0, id));
    // eviction held back while the store buffer hits
    repeat (5) begin
      @(negedge clk_i);
      check("dma_valid_o", dma_valid_o, 1'b0);
      check("snoop_o.valid", snoop_o[id].valid, 1'b1);
      check("snoop_o.index", snoop_o[id].index, req.addr[`CM_OFFSET_W +: `CM_INDEX_W]);
      check("snoop_o.way", snoop_o[id].way, req.victim_way);
    end
    @(posedge clk_i);
    #1;
    snoop_hit_i = '0;
    take_cmd(0, cmd);
    check("dma_req_o", cmd, expect_cmd(req, 1'b1, id));
    send_done(id);
    send_done(id);
    wait_idle(id);
  endtask

  task automatic test_multi();
    cache_miss_pkg::miss_req_t reqs [`CM_HANDLERS];
    cache_miss_pkg::miss_req_t req;
    cache_miss_pkg::dma_req_t  cmd;
    logic [`CM_ID_W-1:0]       id;
    logic [`CM_HANDLERS-1:0]   taken;
    logic [`CM_HANDLERS-1:0]   seen;
    taken = '0;
    seen  = '0;
    // fill every handler while the dma port stays stalled
    for (int i = 0; i < `CM_HANDLERS; i++) begin
      req = make_req(1'b1, 1'b0);
      send_miss(req, id);
      // all idle at start, so lowest free handler is i
      check("miss_id_o", id, i);
      check("miss_id_o reuse", taken[id], 1'b0);
      taken[id] = 1'b1;
      reqs[id]  = req;
    end
    @(negedge clk_i);
    check("miss_ready_o", miss_ready_o, 1'b0);
    check("miss_busy_o", miss_busy_o, {`CM_HANDLERS{1'b1}});
    for (int i = 0; i < `CM_HANDLERS; i++) begin
      take_cmd(2, cmd);
      check("dma_req_o.id repeat", seen[cmd.id], 1'b0);
      seen[cmd.id] = 1'b1;
      check("dma_req_o", cmd, expect_cmd(reqs[cmd.id], 1'b0, cmd.id));
    end
    expect_no_cmd(2);
    check("miss_ready_o", miss_ready_o, 1'b0);
    // free one handler only
    send_done(2);
    wait_idle(2);
    check("miss_busy_o", miss_busy_o, 4'b1011);
    check("miss_ready_o", miss_ready_o, 1'b1);
    check("miss_id_o", miss_id_o, 2'd2);
    for (int i = 0; i < `CM_HANDLERS; i++) begin
      if (i != 2) begin
        send_done(i);
        wait_idle(i);
      end
    end
  endtask

  initial begin
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    miss_valid_i  = 1'b0;
    miss_req_i    = '0;
    dma_ready_i   = 1'b0;
    dma_done_i    = 1'b0;
    dma_done_id_i = '0;
    snoop_hit_i   = '0;
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    test_reset();
    test_clean(1'b1, 1'b0);
    test_clean(1'b0, 1'b1);
    test_dirty();
    test_snoop();
    test_multi();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire
